// ==== hdl/sent_cfg_pkg.sv ====
// sizes are set for short simulation runs; CYCLES_PER_US must be at least 2 and FIFO_DEPTH a power of two
package sent_cfg_pkg;

  // ----------------------------------------
  // timebase
  // ----------------------------------------
  localparam int CYCLES_PER_US = 4;                      // clocks per microsecond
  localparam int US_CNT_W      = $clog2(CYCLES_PER_US);  // prescaler width

  // ----------------------------------------
  // protocol timing
  // ----------------------------------------
  localparam int SYNC_TICKS        = 56;  // calibration pulse
  localparam int NIBBLE_BASE_TICKS = 12;  // pulse for nibble value 0

  // sae crc-4
  localparam logic [3:0] CRC_SEED = 4'b0101;
  localparam logic [3:0] CRC_POLY = 4'b1101;  // x^4+x^3+x^2+1 without the x^4 term

  // config and counter widths
  localparam int TICK_LEN_W  = 8;
  localparam int PAUSE_LEN_W = 16;
  localparam int PULSE_CNT_W = 10;  // longest pulse in ticks must fit here

  // ----------------------------------------
  // frame queue
  // ----------------------------------------
  localparam int FIFO_DEPTH       = 16;
  localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);
  localparam int FIFO_PFULL_LEVEL = FIFO_DEPTH - 2;  // port register plus one in flight

endpackage

// ==== hdl/sent_frame_pkg.sv ====
// frame word bit 31 is ignored and data_len outside 1..6 is not supported
package sent_frame_pkg;

  // ----------------------------------------
  // queued frame word
  // ----------------------------------------
  typedef struct packed {
    logic        spare;     // bit 31 unused
    logic [2:0]  data_len;  // data nibbles 1..6
    logic [3:0]  status;    // status and comm nibble
    logic [23:0] data;      // nibble 1 sits in [23:20]
  } sent_frame_t;

  // ----------------------------------------
  // modes
  // ----------------------------------------
  typedef enum logic [1:0] {
    PAUSE_NONE  = 2'd0,  // crc pulse ends the frame
    PAUSE_FIXED = 2'd1   // pause pulse of pause_len ticks
  } pause_mode_e;

  typedef enum logic {
    CRC_LEGACY      = 1'b0,
    CRC_RECOMMENDED = 1'b1  // one zero nibble appended
  } crc_mode_e;

  // transmitter pulse sequencer
  typedef enum logic [2:0] {
    PULSE_IDLE  = 3'd0,
    PULSE_SYNC  = 3'd1,
    PULSE_DATA  = 3'd2,  // status nibble too
    PULSE_CRC   = 3'd3,
    PULSE_PAUSE = 3'd4
  } pulse_e;

endpackage

// ==== hdl/sent_host_port.sv ====
// cfg_valid is a one-cycle request and new settings wait until the line is idle and the queue is drained
`timescale 1ns/1ps

module sent_host_port (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 frame_valid,
  input  sent_frame_pkg::sent_frame_t          frame_data,
  output logic                                 frame_ready,
  input  logic                                 cfg_valid,
  input  logic [sent_cfg_pkg::TICK_LEN_W-1:0]  cfg_ctick_len,
  input  logic [sent_cfg_pkg::TICK_LEN_W-1:0]  cfg_ltick_len,
  input  sent_frame_pkg::pause_mode_e          cfg_pause_mode,
  input  logic [sent_cfg_pkg::PAUSE_LEN_W-1:0] cfg_pause_len,
  input  sent_frame_pkg::crc_mode_e            cfg_crc_mode,
  output logic                                 cfg_ready,
  output logic                                 wr_valid,
  output sent_frame_pkg::sent_frame_t          wr_data,
  input  logic                                 wr_ready,
  input  logic                                 near_full,
  input  logic                                 empty,
  input  logic                                 line_idle,
  output logic [sent_cfg_pkg::TICK_LEN_W-1:0]  ctick_len,
  output logic [sent_cfg_pkg::TICK_LEN_W-1:0]  ltick_len,
  output sent_frame_pkg::pause_mode_e          pause_mode,
  output logic [sent_cfg_pkg::PAUSE_LEN_W-1:0] pause_len,
  output sent_frame_pkg::crc_mode_e            crc_mode
);
  import sent_cfg_pkg::*;
  import sent_frame_pkg::*;

  logic [TICK_LEN_W-1:0]  sh_ctick_len;   // shadow copy
  logic [TICK_LEN_W-1:0]  sh_ltick_len;
  pause_mode_e            sh_pause_mode;
  logic [PAUSE_LEN_W-1:0] sh_pause_len;
  crc_mode_e              sh_crc_mode;
  logic                   cfg_pending;
  logic                   safe_to_apply;  // nothing queued or on the line
  logic                   frame_take;

  // ----------------------------------------
  // frame path
  // ----------------------------------------
  // near_full leaves room for this register and the word in flight
  assign frame_ready = !near_full && (!wr_valid || wr_ready);
  assign frame_take  = frame_valid && frame_ready;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      wr_valid <= 1'b0;
    else if (frame_take)
      wr_valid <= 1'b1;
    else if (wr_ready)
      wr_valid <= 1'b0;  // drained into the queue
  end

  always_ff @(posedge clk)
  begin
    if (frame_take)
      wr_data <= frame_data;
  end

  // ----------------------------------------
  // configuration
  // ----------------------------------------
  assign safe_to_apply = line_idle && empty && !wr_valid;

  always_ff @(posedge clk)
  begin
    if (cfg_valid)
    begin
      sh_ctick_len  <= cfg_ctick_len;
      sh_ltick_len  <= cfg_ltick_len;
      sh_pause_mode <= cfg_pause_mode;
      sh_pause_len  <= cfg_pause_len;
      sh_crc_mode   <= cfg_crc_mode;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      cfg_pending <= 1'b0;
    else if (cfg_valid)
      cfg_pending <= 1'b1;  // a fresh request wins over apply
    else if (safe_to_apply)
      cfg_pending <= 1'b0;
  end

  // applied settings seen by the transmitter
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ctick_len  <= TICK_LEN_W'(3);  // 3 us tick
      ltick_len  <= TICK_LEN_W'(4);
      pause_mode <= PAUSE_NONE;
      pause_len  <= PAUSE_LEN_W'(12);
      crc_mode   <= CRC_LEGACY;
    end
    else if (cfg_pending && safe_to_apply)
    begin
      ctick_len  <= sh_ctick_len;
      ltick_len  <= sh_ltick_len;
      pause_mode <= sh_pause_mode;
      pause_len  <= sh_pause_len;
      crc_mode   <= sh_crc_mode;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      cfg_ready <= 1'b0;
    else
      cfg_ready <= safe_to_apply && !cfg_pending;
  end

  // offered frame holds until the queue takes it
  a_wr_hold: assert property (@(posedge clk) disable iff (rst)
    wr_valid && !wr_ready |=> wr_valid && $stable(wr_data));

endmodule

// ==== hdl/sent_frame_fifo.sv ====
// rd_data is the head word and only meaningful while rd_valid is high; occupancy never wraps past FIFO_DEPTH
`timescale 1ns/1ps

module sent_frame_fifo (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wr_valid,
  input  sent_frame_pkg::sent_frame_t wr_data,
  output logic                        wr_ready,
  output logic                        rd_valid,
  output sent_frame_pkg::sent_frame_t rd_data,
  input  logic                        rd_ready,
  output logic                        near_full,
  output logic                        empty
);
  import sent_cfg_pkg::*;
  import sent_frame_pkg::*;

  sent_frame_t           mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;  // one extra bit for full
  logic                  full;
  logic                  do_wr;
  logic                  do_rd;

  // ----------------------------------------
  // flags
  // ----------------------------------------
  assign full      = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
  assign empty     = (count == '0);
  assign near_full = (count >= (FIFO_PTR_W + 1)'(FIFO_PFULL_LEVEL));

  assign wr_ready = !full;
  assign rd_valid = !empty;
  assign do_wr    = wr_valid && wr_ready;
  assign do_rd    = rd_ready && rd_valid;

  // fwft head straight from the array
  assign rd_data = mem[rd_ptr];

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or both
      endcase
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  // host port threshold must keep writes away from a full queue
  a_no_wr_full: assert property (@(posedge clk) disable iff (rst)
    wr_valid |-> !full);

  // transmitter only pops a word it has seen
  a_no_rd_empty: assert property (@(posedge clk) disable iff (rst)
    rd_ready |-> !empty);

endmodule

// ==== hdl/sent_crc4.sv ====
// frame_len must be 1..6 and crc_start must not repeat before crc_done; crc_value holds until the next start
`timescale 1ns/1ps

module sent_crc4 (
  input  logic        clk,
  input  logic        rst,
  input  logic        crc_start,
  input  logic        crc_mode,
  input  logic [2:0]  frame_len,
  input  logic [23:0] frame_nibbles,
  output logic        crc_done,
  output logic [3:0]  crc_value
);
  import sent_cfg_pkg::*;

  logic [23:0] nib_sr;     // next nibble on top
  logic [2:0]  fold_cnt;   // folds left
  logic        zero_tail;  // recommended mode
  logic        busy;
  logic [3:0]  fold_in;
  logic [3:0]  fold_out;

  // last fold of recommended mode takes a zero nibble
  assign fold_in = (zero_tail && fold_cnt == 3'd1) ? 4'd0 : nib_sr[23:20];

  // state times x^4 mod poly, then add the nibble
  always_comb
  begin
    fold_out = crc_value;
    for (int i = 0; i < 4; i++)
      fold_out = {fold_out[2:0], 1'b0} ^ (fold_out[3] ? CRC_POLY : 4'd0);
    fold_out = fold_out ^ fold_in;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy     <= 1'b0;
      fold_cnt <= '0;
      crc_done <= 1'b0;
    end
    else
    begin
      crc_done <= 1'b0;  // single cycle
      if (crc_start)
      begin
        busy     <= 1'b1;
        fold_cnt <= frame_len + {2'b00, crc_mode};
      end
      else if (busy)
      begin
        fold_cnt <= fold_cnt - 1'b1;
        if (fold_cnt == 3'd1)
        begin
          busy     <= 1'b0;
          crc_done <= 1'b1;  // with the final fold
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (crc_start)
    begin
      nib_sr    <= frame_nibbles;
      zero_tail <= crc_mode;
      crc_value <= CRC_SEED;
    end
    else if (busy)
    begin
      nib_sr    <= {nib_sr[19:0], 4'd0};
      crc_value <= fold_out;
    end
  end

  // transmitter starts one frame at a time
  a_no_restart: assert property (@(posedge clk) disable iff (rst) crc_start |-> !busy);

endmodule

// ==== hdl/sent_frame_tx.sv ====
// settings must stay stable while not idle; ctick_len nonzero, ltick_len below 12 and below pause_len, pause_len under 1024
`timescale 1ns/1ps

module sent_frame_tx (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 rd_valid,
  input  sent_frame_pkg::sent_frame_t          rd_data,
  output logic                                 rd_ready,
  input  logic [sent_cfg_pkg::TICK_LEN_W-1:0]  ctick_len,
  input  logic [sent_cfg_pkg::TICK_LEN_W-1:0]  ltick_len,
  input  sent_frame_pkg::pause_mode_e          pause_mode,
  input  logic [sent_cfg_pkg::PAUSE_LEN_W-1:0] pause_len,
  input  sent_frame_pkg::crc_mode_e            crc_mode,
  output logic                                 line_idle,
  output logic                                 sent
);
  import sent_cfg_pkg::*;
  import sent_frame_pkg::*;

  pulse_e                 state;
  logic [US_CNT_W-1:0]    us_cnt;     // clocks in the current us
  logic [TICK_LEN_W-1:0]  tick_cnt;   // us in the current tick
  logic                   us_end;
  logic                   tick;       // tick strobe
  logic [PULSE_CNT_W-1:0] pulse_cnt;  // ticks into the pulse
  logic [PULSE_CNT_W-1:0] pulse_len;
  logic                   pulse_end;
  logic                   frame_end;
  logic                   load;
  logic [27:0]            nib_sr;     // status nibble on top
  logic [2:0]             data_len;
  logic [2:0]             nib_cnt;    // 0 is status
  logic [3:0]             crc_nib;
  logic                   crc_start;
  logic                   crc_done;
  logic [3:0]             crc_value;

  // ----------------------------------------
  // timebase
  // ----------------------------------------
  assign us_end = (us_cnt == US_CNT_W'(CYCLES_PER_US - 1));
  assign tick   = us_end && (tick_cnt == ctick_len - 1'b1);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      us_cnt   <= '0;
      tick_cnt <= '0;
    end
    else if (state == PULSE_IDLE)
    begin
      us_cnt   <= '0;  // held while idle so the first tick is whole
      tick_cnt <= '0;
    end
    else
    begin
      us_cnt <= us_end ? '0 : us_cnt + 1'b1;
      if (us_end)
        tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
    end
  end

  // ----------------------------------------
  // sequencer
  // ----------------------------------------
  always_comb
  begin
    case (state)
      PULSE_DATA:  pulse_len = PULSE_CNT_W'(NIBBLE_BASE_TICKS) + PULSE_CNT_W'(nib_sr[27:24]);
      PULSE_CRC:   pulse_len = PULSE_CNT_W'(NIBBLE_BASE_TICKS) + PULSE_CNT_W'(crc_nib);
      PULSE_PAUSE: pulse_len = pause_len[PULSE_CNT_W-1:0];
      default:     pulse_len = PULSE_CNT_W'(SYNC_TICKS);
    endcase
  end

  assign pulse_end = tick && (pulse_cnt == pulse_len - 1'b1);
  assign frame_end = pulse_end && (state == PULSE_PAUSE ||
                                   (state == PULSE_CRC && pause_mode == PAUSE_NONE));
  assign load      = rd_valid && (state == PULSE_IDLE || frame_end);  // back-to-back
  assign rd_ready  = load;
  assign line_idle = (state == PULSE_IDLE);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state     <= PULSE_IDLE;
      pulse_cnt <= '0;
      nib_cnt   <= '0;
      crc_start <= 1'b0;
    end
    else
    begin
      crc_start <= load;  // engine reads nib_sr a cycle after load
      if (load)
      begin
        state     <= PULSE_SYNC;
        pulse_cnt <= '0;
        nib_cnt   <= '0;
      end
      else if (state != PULSE_IDLE && tick)
      begin
        pulse_cnt <= pulse_end ? '0 : pulse_cnt + 1'b1;
        if (pulse_end)
        begin
          case (state)
            PULSE_SYNC: state <= PULSE_DATA;
            PULSE_DATA:
            begin
              nib_cnt <= nib_cnt + 1'b1;
              if (nib_cnt == data_len)
                state <= PULSE_CRC;  // status plus data_len nibbles sent
            end
            PULSE_CRC: state <= (pause_mode == PAUSE_NONE) ? PULSE_IDLE : PULSE_PAUSE;
            default:   state <= PULSE_IDLE;  // queue ran dry
          endcase
        end
      end
    end
  end

  // frame payload
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      nib_sr   <= {rd_data.status, rd_data.data};
      data_len <= rd_data.data_len;
    end
    else if (state == PULSE_DATA && pulse_end)
      nib_sr <= {nib_sr[23:0], 4'd0};
    if (crc_done)
      crc_nib <= crc_value;  // long before the crc pulse
  end

  sent_crc4 sent_crc4_i (
    .clk           (clk),
    .rst           (rst),
    .crc_start     (crc_start),
    .crc_mode      (crc_mode),
    .frame_len     (data_len),
    .frame_nibbles (nib_sr[23:0]),  // data only
    .crc_done      (crc_done),
    .crc_value     (crc_value)
  );

  // ----------------------------------------
  // line driver
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      sent <= 1'b1;
    else
      sent <= !(state != PULSE_IDLE && pulse_cnt < PULSE_CNT_W'(ltick_len));
  end

  // every pulse ends high so idle never starts low
  a_idle_high: assert property (@(posedge clk) disable iff (rst) line_idle |-> sent);

endmodule

// ==== hdl/sent_tx_top.sv ====
// one SENT channel per instance; frame_ready drops two frames before the queue is actually full
`timescale 1ns/1ps

module sent_tx_top (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 frame_valid,
  input  sent_frame_pkg::sent_frame_t          frame_data,
  output logic                                 frame_ready,
  input  logic                                 cfg_valid,
  input  logic [sent_cfg_pkg::TICK_LEN_W-1:0]  cfg_ctick_len,
  input  logic [sent_cfg_pkg::TICK_LEN_W-1:0]  cfg_ltick_len,
  input  sent_frame_pkg::pause_mode_e          cfg_pause_mode,
  input  logic [sent_cfg_pkg::PAUSE_LEN_W-1:0] cfg_pause_len,
  input  sent_frame_pkg::crc_mode_e            cfg_crc_mode,
  output logic                                 cfg_ready,
  output logic                                 sent
);
  import sent_cfg_pkg::*;
  import sent_frame_pkg::*;

  // host port to queue
  logic                   wr_valid;
  sent_frame_t            wr_data;
  logic                   wr_ready;
  logic                   near_full;
  logic                   empty;
  // queue to transmitter
  logic                   rd_valid;
  sent_frame_t            rd_data;
  logic                   rd_ready;
  // applied settings and line status
  logic [TICK_LEN_W-1:0]  ctick_len;
  logic [TICK_LEN_W-1:0]  ltick_len;
  pause_mode_e            pause_mode;
  logic [PAUSE_LEN_W-1:0] pause_len;
  crc_mode_e              crc_mode;
  logic                   line_idle;

  // port names match the wires above
  sent_host_port  sent_host_port_i  (.*);
  sent_frame_fifo sent_frame_fifo_i (.*);
  sent_frame_tx   sent_frame_tx_i   (.*);

endmodule

// ==== tests/tb_sent_tx.sv ====
// trace path is relative to the project root; the decoder peeks at the transmitter's line_idle to close a pulse before idle
`timescale 1ns/1ps

module tb_sent_tx;
  import sent_cfg_pkg::*;
  import sent_frame_pkg::*;

  logic                   clk;
  logic                   rst;
  logic                   frame_valid;
  sent_frame_t            frame_data;
  logic                   frame_ready;
  logic                   cfg_valid;
  logic [TICK_LEN_W-1:0]  cfg_ctick_len;
  logic [TICK_LEN_W-1:0]  cfg_ltick_len;
  pause_mode_e            cfg_pause_mode;
  logic [PAUSE_LEN_W-1:0] cfg_pause_len;
  crc_mode_e              cfg_crc_mode;
  logic                   cfg_ready;
  logic                   sent;

  // trace records in file order
  bit          rec_is_cfg[$];
  int          rec_v0[$];    // ctick or expected crc
  int          rec_v1[$];
  int          rec_v2[$];
  int          rec_v3[$];
  int          rec_v4[$];
  logic [31:0] rec_word[$];
  // expected frames with the settings they go out under
  logic [31:0] frm_word[$];
  int          frm_crc[$];
  int          frm_tc[$];    // clocks per tick
  int          frm_lt[$];
  int          frm_pm[$];
  int          frm_pl[$];
  bit          frm_last[$];  // queue drains after this one
  // decoded pulses, in clocks
  int          iv_len[$];
  int          iv_low[$];
  bit          iv_idle[$];   // closed by the line going idle

  int cycle_limit;
  int run_cycles;
  int rnd;
  bit saw_backpressure;

  sent_tx_top sent_tx_top_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // checks and trace
  // ----------------------------------------
  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual)
    begin
      $display("ERROR %s expected %0d actual %0d", name, expected, actual);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic abort_bad_trace(input string what);
    $display("trace file problem: %s", what);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic read_trace();
    int          fd;
    int          code;
    string       tag;
    string       skip;
    int          a, b, c, d, e;
    logic [31:0] w;
    int          crc;
    int          tc, lt, pm, pl;
    tc = 3 * CYCLES_PER_US;  // reset defaults
    lt = 4;
    pm = 0;
    pl = 12;
    cycle_limit = 1000;
    fd = $fopen("tests/sent_tx_trace.txt", "r");
    if (fd == 0)
      abort_bad_trace("cannot open tests/sent_tx_trace.txt");
    while (!$feof(fd))
    begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1)
        break;
      if (tag == "#")
        code = $fgets(skip, fd);  // comment line
      else if (tag == "C")
      begin
        code = $fscanf(fd, "%d %d %d %d %d", a, b, c, d, e);
        if (code != 5)
          abort_bad_trace("config record with missing fields");
        rec_is_cfg.push_back(1'b1);
        rec_v0.push_back(a);
        rec_v1.push_back(b);
        rec_v2.push_back(c);
        rec_v3.push_back(d);
        rec_v4.push_back(e);
        rec_word.push_back('0);
        if (frm_last.size() > 0)
          frm_last[frm_last.size() - 1] = 1'b1;  // config waits for the drain
        tc = a * CYCLES_PER_US;
        lt = b;
        pm = c;
        pl = d;
        cycle_limit += 500;  // reconfig wait
      end
      else
      begin
        if (tag != "F")
          abort_bad_trace({"unknown record tag ", tag});
        code = $fscanf(fd, "%h %h", w, crc);
        if (code != 2)
          abort_bad_trace("frame record with missing fields");
        rec_is_cfg.push_back(1'b0);
        rec_v0.push_back(crc);
        rec_v1.push_back(0);
        rec_v2.push_back(0);
        rec_v3.push_back(0);
        rec_v4.push_back(0);
        rec_word.push_back(w);
        frm_word.push_back(w);
        frm_crc.push_back(crc);
        frm_tc.push_back(tc);
        frm_lt.push_back(lt);
        frm_pm.push_back(pm);
        frm_pl.push_back(pl);
        frm_last.push_back(1'b0);
        // sync, 7 nibbles and crc at their longest, plus pause
        cycle_limit += 2 * (SYNC_TICKS + 8 * 27 + (pm == 1 ? pl : 0)) * tc;
      end
    end
    $fclose(fd);
    if (frm_last.size() > 0)
      frm_last[frm_last.size() - 1] = 1'b1;
  endtask

  // ----------------------------------------
  // line decoder
  // ----------------------------------------
  int cyc = 0;
  bit prev_sent = 1'b1;
  bit prev_idle = 1'b1;
  bit pulse_open = 1'b0;
  int open_start;
  int low_len;

  always @(negedge clk)
  begin
    if (!rst)
    begin
      cyc++;
      if (prev_sent && !sent)
      begin
        if (pulse_open)
        begin
          iv_len.push_back(cyc - open_start);  // falling edge to falling edge
          iv_low.push_back(low_len);
          iv_idle.push_back(1'b0);
        end
        pulse_open = 1'b1;
        open_start = cyc;
      end
      else if (!prev_sent && sent)
        low_len = cyc - open_start;
      // going idle ends the pulse one clock before sent would show it
      if (sent_tx_top_i.line_idle && !prev_idle && pulse_open)
      begin
        iv_len.push_back(cyc + 1 - open_start);
        iv_low.push_back(low_len);
        iv_idle.push_back(1'b1);
        pulse_open = 1'b0;
      end
      prev_sent = sent;
      prev_idle = sent_tx_top_i.line_idle;
    end
  end

  always @(posedge clk)
  begin
    if (!rst)
    begin
      run_cycles++;
      if (run_cycles > cycle_limit)
      begin
        $display("run did not finish within %0d cycles", cycle_limit);
        $display("Verification failed");
        $fatal(1);
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic offer_frame(input logic [31:0] w);
    @(posedge clk);
    frame_valid <= 1'b1;
    frame_data  <= w;
    @(negedge clk);
    while (!frame_ready)
    begin
      saw_backpressure = 1'b1;
      @(negedge clk);
    end
    @(posedge clk);  // transfer edge
    frame_valid <= 1'b0;
    repeat (rnd & 3)
      @(posedge clk);
    rnd = $urandom;
  endtask

  task automatic issue_config(input int r);
    int pm;
    int cm;
    pm = rec_v2[r];
    cm = rec_v4[r];
    @(posedge clk);
    cfg_valid      <= 1'b1;
    cfg_ctick_len  <= TICK_LEN_W'(rec_v0[r]);
    cfg_ltick_len  <= TICK_LEN_W'(rec_v1[r]);
    cfg_pause_mode <= pause_mode_e'(pm[1:0]);
    cfg_pause_len  <= PAUSE_LEN_W'(rec_v3[r]);
    cfg_crc_mode   <= crc_mode_e'(cm[0]);
    @(posedge clk);
    cfg_valid <= 1'b0;
    repeat (2)
      @(posedge clk);  // cfg_ready lags the request
    @(negedge clk);
    while (!cfg_ready)
      @(negedge clk);
  endtask

  task automatic run_producer();
    for (int r = 0; r < rec_is_cfg.size(); r++)
    begin
      if (rec_is_cfg[r])
        issue_config(r);
      else
        offer_frame(rec_word[r]);
    end
  endtask

  task automatic take_pulse(output int len, output int low, output bit idle);
    while (iv_len.size() == 0)
      @(posedge clk);
    len  = iv_len.pop_front();
    low  = iv_low.pop_front();
    idle = iv_idle.pop_front();
  endtask

  task automatic check_pulse(input string name, input int ticks, input int tc, input int lt,
                             input bit last);
    int len;
    int low;
    bit idle;
    take_pulse(len, low, idle);
    check_value({name, " length"}, ticks * tc, len);
    check_value({name, " low phase"}, lt * tc, low);
    check_value({name, " line idle after"}, int'(last), int'(idle));
  endtask

  task automatic run_checker();
    logic [31:0] w;
    int          tc;
    int          lt;
    int          len;
    int          low;
    bit          idle;
    bit          crc_last;
    for (int f = 0; f < frm_word.size(); f++)
    begin
      w  = frm_word[f];
      tc = frm_tc[f];
      lt = frm_lt[f];
      crc_last = (frm_pm[f] == 1) ? 1'b0 : frm_last[f];  // mode 0 ends on the crc
      check_pulse($sformatf("frame %0d sync", f), SYNC_TICKS, tc, lt, 1'b0);
      check_pulse($sformatf("frame %0d status", f), NIBBLE_BASE_TICKS + int'(w[27:24]), tc, lt,
                  1'b0);
      for (int n = 0; n < int'(w[30:28]); n++)
        check_pulse($sformatf("frame %0d data %0d", f, n),
                    NIBBLE_BASE_TICKS + int'(w[23 - 4 * n -: 4]), tc, lt, 1'b0);
      take_pulse(len, low, idle);
      check_value($sformatf("frame %0d crc whole ticks", f), 0, len % tc);
      check_value($sformatf("frame %0d crc", f), frm_crc[f], len / tc - NIBBLE_BASE_TICKS);
      check_value($sformatf("frame %0d crc low phase", f), lt * tc, low);
      check_value($sformatf("frame %0d crc line idle after", f), int'(crc_last), int'(idle));
      if (frm_pm[f] == 1)
        check_pulse($sformatf("frame %0d pause", f), frm_pl[f], tc, lt, frm_last[f]);
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial
  begin
    rnd              = $urandom(53);
    rst              = 1'b1;
    frame_valid      = 1'b0;
    frame_data       = '0;
    cfg_valid        = 1'b0;
    cfg_ctick_len    = TICK_LEN_W'(3);
    cfg_ltick_len    = TICK_LEN_W'(4);
    cfg_pause_mode   = PAUSE_NONE;
    cfg_pause_len    = PAUSE_LEN_W'(12);
    cfg_crc_mode     = CRC_LEGACY;
    run_cycles       = 0;
    saw_backpressure = 1'b0;
    read_trace();
    repeat (8)
      @(posedge clk);
    @(negedge clk);
    check_value("sent in reset", 1, int'(sent));
    check_value("cfg_ready in reset", 0, int'(cfg_ready));
    @(posedge clk);
    rst <= 1'b0;
    repeat (2)
      @(posedge clk);
    @(negedge clk);
    check_value("idle sent", 1, int'(sent));
    check_value("idle cfg_ready", 1, int'(cfg_ready));
    check_value("idle frame_ready", 1, int'(frame_ready));
    fork
      run_producer();
      run_checker();
    join
    repeat (20)
      @(negedge clk);
    check_value("pulses left over", 0, iv_len.size());
    check_value("frame_ready dropped in burst", 1, int'(saw_backpressure));
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== tests/sent_tx_trace.txt ====
# C ctick_us ltick pause_mode pause_len crc_mode (decimal)
# F frame_word expected_crc (hex)
C 1 3 0 12 0
F 10100000 2
F 11200000 1
F 12300000 0
F 13400000 7
F 14500000 6
F 15600000 5
F 16700000 4
F 17800000 B
F 18900000 A
F 19A00000 9
F 1AB00000 8
F 1BC00000 F
F 1CD00000 E
F 1DE00000 D
F 1EF00000 C
F 1F000000 3
F 10F00000 C
F 65123456 D
C 2 4 1 20 1
F 3A9C4000 7
F 20F00000 5
F 47ABCD00 F
C 3 5 1 15 0
F 5E135790 6
F 10A00000 9

// ==== project.f ====
hdl/sent_cfg_pkg.sv
hdl/sent_frame_pkg.sv
hdl/sent_host_port.sv
hdl/sent_frame_fifo.sv
hdl/sent_crc4.sv
hdl/sent_frame_tx.sv
hdl/sent_tx_top.sv
tests/tb_sent_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the SENT transmitter testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module tb_sent_tx -o tb_sent_tx
if [ $? -ne 0 ]; then
  echo "build step failed"
  exit 1
fi

./obj_dir/tb_sent_tx > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

if grep -qx "Verification passed" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1
